/* sources.f */
serdes_pkg.sv
pattern_config_if.sv
pattern_config.sv
prbs_generator.sv
pattern_sequencer.sv
link_serializer.sv
serdes_test_top.sv
serdes_sva.sv
tb_serdes.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the serdes link test simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f sources.f --top-module tb_serdes

output=$(./obj_dir/Vtb_serdes || true)
echo "$output"

if echo "$output" | grep -q -x "Testbench passed"; then
	exit 0
else
	exit 1
fi

/* tb_serdes.sv */
/*
 * serdes link test testbench
 * drives the register port, deserializes the serial line and checks every pattern mode
 */
`timescale 1ns/1ps

module tb_serdes;

	localparam int BITS = serdes_pkg::BITS_PER_FRAME;
	localparam int WIDTH = serdes_pkg::WORD_WIDTH;

	logic clock;
	logic reset;
	logic write;
	serdes_pkg::addr_t address;
	serdes_pkg::word_t write_data;
	logic serial_out;
	serdes_pkg::word_t data_word;
	logic frame_sync;

	int frame_pos; // bit on the line, 0 start .. 11 stop
	int sync_seen; // sync pulses seen while receiving
	logic [31:0] rand_state;
	serdes_pkg::prbs_t lfsr_model;

	serdes_test_top u_dut (
		.clock(clock),
		.reset(reset),
		.write(write),
		.address(address),
		.write_data(write_data),
		.serial_out(serial_out),
		.data_word(data_word),
		.frame_sync(frame_sync)
	);

	always #2 clock = ~clock;

	// first load comes on the first edge after reset release
	always @(posedge clock) begin
		if (reset) begin
			frame_pos <= BITS - 1;
		end else if (frame_pos == BITS - 1) begin
			frame_pos <= 0;
		end else begin
			frame_pos <= frame_pos + 1;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// galois step, right shift with the taps folded in
	function automatic serdes_pkg::prbs_t lfsr_step(input serdes_pkg::prbs_t state);
		serdes_pkg::prbs_t shifted;
		shifted = {1'b0, state[serdes_pkg::PRBS_WIDTH-1:1]};
		if (state[0]) begin
			shifted = shifted ^ serdes_pkg::PRBS_TAPS;
		end
		return shifted;
	endfunction

	function automatic serdes_pkg::word_t expected_frame_word(input int slot,
			input serdes_pkg::prbs_t lfsr);
		serdes_pkg::word_t w;
		w = '0;
		if (slot >= 1 && slot <= serdes_pkg::RAMP_LAST) begin
			for (int b = 0; b < WIDTH; b++) begin
				if (b >= WIDTH - slot) begin
					w[b] = 1'b1; // top slot bits set
				end
			end
		end else if (slot == serdes_pkg::ALT_SLOT) begin
			w = serdes_pkg::ALT_WORD;
		end else if (slot == serdes_pkg::PRBS_SLOT) begin
			w = lfsr[WIDTH-1:0];
		end
		return w;
	endfunction

	function automatic serdes_pkg::word_t control_word(input logic enable,
			input serdes_pkg::pattern_mode_t mode);
		serdes_pkg::word_t value;
		value = '0;
		value[0] = enable;
		value[2:1] = mode;
		return value;
	endfunction

	// returns once the new value is visible to the sequencer
	task automatic write_register(input serdes_pkg::addr_t addr, input serdes_pkg::word_t value);
		@(posedge clock);
		write <= 1'b1;
		address <= addr;
		write_data <= value;
		@(posedge clock);
		write <= 1'b0;
		@(posedge clock);
	endtask

	task automatic sample_line();
		@(negedge clock);
		if (frame_sync) begin
			sync_seen++;
		end
	endtask

	task automatic receive_word(output serdes_pkg::word_t word);
		logic [BITS-1:0] bits;
		int waited;
		waited = 0;
		do begin
			sample_line();
			waited++;
			if (waited > 2 * BITS) begin
				abort_run("timeout while waiting for a start bit on the serial line");
			end
		end while (frame_pos != 0);
		bits[0] = serial_out;
		for (int i = 1; i < BITS; i++) begin
			sample_line();
			bits[i] = serial_out;
		end
		check_value("start bit", bits[0], 1);
		check_value("stop bit", bits[BITS-1], 0);
		word = bits[WIDTH:1]; // lsb first on the line
	endtask

	task automatic wait_for_sync(input int limit);
		int waited;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > limit) begin
				abort_run("timeout while waiting for frame_sync");
			end
		end while (!frame_sync);
	endtask

	task automatic test_reset_framing();
		serdes_pkg::word_t word;
		@(negedge clock);
		check_value("serial_out after reset", serial_out, 0);
		check_value("frame_sync after reset", frame_sync, 0);
		check_value("data_word after reset", data_word, 0);
		repeat (3) begin
			receive_word(word);
			check_value("disabled word", word, 0);
		end
	endtask

	task automatic test_frame_pattern();
		serdes_pkg::word_t word;
		int first;
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b1, serdes_pkg::MODE_FRAME));
		wait_for_sync(3 * BITS);
		check_value("data_word at sync", data_word, 0);
		first = sync_seen;
		for (int slot = 0; slot < serdes_pkg::FRAME_SLOTS; slot++) begin
			receive_word(word);
			check_value($sformatf("frame slot %0d", slot), word,
				expected_frame_word(slot, lfsr_model));
			if (slot == serdes_pkg::PRBS_SLOT) begin
				lfsr_model = lfsr_step(lfsr_model);
			end
		end
		check_value("syncs per frame", sync_seen - first, 1);
	endtask

	task automatic test_prbs_mode();
		serdes_pkg::word_t word;
		int steps;
		write_register(serdes_pkg::ADDR_RESEED, '0);
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b1, serdes_pkg::MODE_PRBS));
		receive_word(word); // still from the frame pattern
		receive_word(word);
		lfsr_model = serdes_pkg::PRBS_SEED;
		steps = 0;
		while (lfsr_model[WIDTH-1:0] != word) begin
			lfsr_model = lfsr_step(lfsr_model);
			steps++;
			if (steps > 64) begin
				abort_run("first PRBS word not found in the LFSR model sequence");
			end
		end
		for (int n = 0; n < 40; n++) begin
			lfsr_model = lfsr_step(lfsr_model);
			receive_word(word);
			check_value("PRBS word", word, lfsr_model[WIDTH-1:0]);
		end
	endtask

	task automatic test_fixed_word();
		serdes_pkg::word_t word;
		serdes_pkg::word_t value;
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b1, serdes_pkg::MODE_FIXED));
		repeat (4) begin
			rand_state = xorshift(rand_state);
			value = rand_state[WIDTH-1:0];
			write_register(serdes_pkg::ADDR_FIXED, value);
			receive_word(word); // may still be the old word
			repeat (3) begin
				receive_word(word);
				check_value("fixed word", word, value);
			end
		end
	endtask

	task automatic test_disable();
		serdes_pkg::word_t word;
		int first;
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b1, serdes_pkg::MODE_FRAME));
		wait_for_sync((serdes_pkg::FRAME_SLOTS + 2) * BITS);
		for (int slot = 0; slot < 5; slot++) begin
			receive_word(word);
			check_value($sformatf("slot %0d before disable", slot), word,
				expected_frame_word(slot, lfsr_model));
		end
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b0, serdes_pkg::MODE_FRAME));
		receive_word(word);
		first = sync_seen;
		for (int n = 0; n < serdes_pkg::FRAME_SLOTS + 2; n++) begin
			receive_word(word);
			check_value("word while disabled", word, 0);
		end
		check_value("syncs while disabled", sync_seen - first, 0);
		write_register(serdes_pkg::ADDR_CONTROL, control_word(1'b1, serdes_pkg::MODE_FRAME));
		wait_for_sync(3 * BITS);
		check_value("data_word at restart sync", data_word, 0);
		for (int slot = 0; slot <= serdes_pkg::ALT_SLOT; slot++) begin
			receive_word(word);
			check_value($sformatf("slot %0d after restart", slot), word,
				expected_frame_word(slot, lfsr_model));
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		write = 1'b0;
		address = '0;
		write_data = '0;
		sync_seen = 0;
		rand_state = 32'h335b;
		lfsr_model = serdes_pkg::PRBS_SEED;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		test_reset_framing();
		test_frame_pattern();
		test_prbs_mode();
		test_fixed_word();
		test_disable();
		if (u_dut.u_sva.failure_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run("concurrent assertions on the serial framing failed");
		end
	end

endmodule

/* serdes_sva.sv */
/*
 * serdes link assertions
 * load period, stop bit, single-cycle frame sync
 */
`timescale 1ns/1ps

module serdes_sva (
	input logic clock,
	input logic reset,
	input logic load,
	input logic serial_out,
	input logic frame_sync
);

	localparam int PERIOD = serdes_pkg::BITS_PER_FRAME;

	int failure_count = 0;
	logic seen_load;
	serdes_pkg::bit_count_t load_gap; // edges since the last load

	always_ff @(posedge clock) begin
		if (reset) begin
			seen_load <= 1'b0;
			load_gap <= '0;
		end else if (load) begin
			seen_load <= 1'b1;
			load_gap <= 4'd1;
		end else if (load_gap != 4'hf) begin
			load_gap <= load_gap + 4'd1; // saturates
		end
	end

	load_period: assert property (@(posedge clock) disable iff (reset)
		load |-> ##PERIOD load)
		else begin
			failure_count++;
			$error("load did not recur after a full serial frame");
		end

	load_spacing: assert property (@(posedge clock) disable iff (reset)
		(seen_load && load) |-> (load_gap == PERIOD))
		else begin
			failure_count++;
			$error("load came early");
		end

	stop_bit: assert property (@(posedge clock) disable iff (reset)
		load |-> (serial_out == 1'b0))
		else begin
			failure_count++;
			$error("stop bit is not 0");
		end

	sync_single: assert property (@(posedge clock) disable iff (reset)
		frame_sync |=> !frame_sync)
		else begin
			failure_count++;
			$error("frame_sync held for two cycles");
		end

endmodule

// serializer load and line plus sequencer sync, seen from the top
bind serdes_test_top serdes_sva u_sva (
	.clock(clock),
	.reset(reset),
	.load(load),
	.serial_out(serial_out),
	.frame_sync(frame_sync)
);

/* serdes_test_top.sv */
/*
 * serdes link test top
 * register block, pattern sequencer and serializer on one clock
 */
`timescale 1ns/1ps

module serdes_test_top (
	input logic clock,
	input logic reset,
	input logic write,
	input serdes_pkg::addr_t address,
	input serdes_pkg::word_t write_data,
	output logic serial_out,
	output serdes_pkg::word_t data_word,
	output logic frame_sync
);

	logic load; // one pulse per serial frame

	pattern_config_if cfg ();

	pattern_config u_config (
		.clock(clock),
		.reset(reset),
		.write(write),
		.address(address),
		.write_data(write_data),
		.config_port(cfg.source)
	);

	pattern_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.load(load),
		.config_port(cfg.sink),
		.data_word(data_word),
		.frame_sync(frame_sync)
	);

	link_serializer u_serializer (
		.clock(clock),
		.reset(reset),
		.data_word(data_word),
		.load(load),
		.serial_out(serial_out)
	);

endmodule

/* link_serializer.sv */
/*
 * link serializer
 * 12 cycle frame timer, captures a word on load and sends start, lsb-first data, stop
 */
`timescale 1ns/1ps

module link_serializer (
	input logic clock,
	input logic reset,
	input serdes_pkg::word_t data_word,
	output logic load,
	output logic serial_out
);

	localparam serdes_pkg::bit_count_t COUNT_LAST =
		serdes_pkg::bit_count_t'(serdes_pkg::BITS_PER_FRAME - 1);

	localparam logic START_BIT = 1'b1;
	localparam logic STOP_BIT = 1'b0;

	serdes_pkg::bit_count_t bit_count;
	logic [serdes_pkg::WORD_WIDTH:0] shift_reg; // data bits then stop

	// frame timer, 0..11
	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= '0;
		end else if (bit_count == COUNT_LAST) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	assign load = (bit_count == '0); // first cycle after reset too

	/* serial_out is the bottom bit of the frame register, so the start bit
	   shows in the cycle after load and the stop bit in the cycle of the
	   next load */
	always_ff @(posedge clock) begin
		if (load) begin
			shift_reg <= {STOP_BIT, data_word};
		end else begin
			shift_reg <= {1'b0, shift_reg[serdes_pkg::WORD_WIDTH:1]};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			serial_out <= 1'b0;
		end else if (load) begin
			serial_out <= START_BIT;
		end else begin
			serial_out <= shift_reg[0]; // lsb first
		end
	end

endmodule

/* pattern_sequencer.sv */
/*
 * link test pattern sequencer
 * walks a 32 slot frame on each load, picks the word per mode and flags slot 0
 */
`timescale 1ns/1ps

module pattern_sequencer (
	input logic clock,
	input logic reset,
	input logic load,
	pattern_config_if.sink config_port,
	output serdes_pkg::word_t data_word,
	output logic frame_sync
);

	localparam serdes_pkg::slot_t SLOT_LAST = serdes_pkg::slot_t'(serdes_pkg::FRAME_SLOTS - 1);

	serdes_pkg::slot_t slot;
	serdes_pkg::slot_t next_slot;
	serdes_pkg::prbs_t prbs_word;
	serdes_pkg::word_t prbs_low;
	serdes_pkg::word_t ramp_word;
	serdes_pkg::word_t slot_word;
	logic uses_prbs;
	logic advance;

	prbs_generator u_prbs (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.reseed(config_port.reseed),
		.word(prbs_word)
	);

	assign next_slot = (slot == SLOT_LAST) ? '0 : slot + 1'b1; // wraps at frame end
	assign prbs_low = prbs_word[serdes_pkg::WORD_WIDTH-1:0];

	// thermometer ramp, n msbs set for slot n
	assign ramp_word = ~(serdes_pkg::word_t'('1) >> next_slot);

	// word for the slot about to be registered
	always_comb begin
		slot_word = '0;
		uses_prbs = 1'b0;
		case (config_port.mode)
			serdes_pkg::MODE_PRBS: begin
				slot_word = prbs_low;
				uses_prbs = 1'b1;
			end
			serdes_pkg::MODE_FIXED: begin
				slot_word = config_port.fixed_word;
			end
			default: begin // frame pattern, also code 3
				if (next_slot == '0) begin
					slot_word = '0;
				end else if (next_slot <= serdes_pkg::RAMP_LAST) begin
					slot_word = ramp_word;
				end else if (next_slot == serdes_pkg::ALT_SLOT) begin
					slot_word = serdes_pkg::ALT_WORD;
				end else if (next_slot == serdes_pkg::PRBS_SLOT) begin
					slot_word = prbs_low;
					uses_prbs = 1'b1;
				end
			end
		endcase
	end

	// lfsr steps on the same edge that takes its word
	assign advance = load && config_port.enable && uses_prbs;

	/* while disabled the slot sits on the last one so the first
	   enabled load lands on slot 0 and raises sync */
	always_ff @(posedge clock) begin
		frame_sync <= 1'b0;
		if (reset) begin
			slot <= '0;
			data_word <= '0;
		end else if (!config_port.enable) begin
			slot <= SLOT_LAST;
			data_word <= '0;
		end else if (load) begin
			slot <= next_slot;
			data_word <= slot_word;
			frame_sync <= (next_slot == '0);
		end
	end

endmodule

/* prbs_generator.sv */
/*
 * 32-bit galois LFSR
 * steps once per advance request, reseed returns it to the seed value
 */
`timescale 1ns/1ps

module prbs_generator (
	input logic clock,
	input logic reset,
	input logic advance,
	input logic reseed,
	output serdes_pkg::prbs_t word
);

	serdes_pkg::prbs_t next_word;

	// one galois step, taps folded in when bit 0 falls out
	always_comb begin
		next_word = word >> 1;
		if (word[0]) begin
			next_word = next_word ^ serdes_pkg::PRBS_TAPS;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			word <= serdes_pkg::PRBS_SEED;
		end else if (reseed) begin
			word <= serdes_pkg::PRBS_SEED; // wins over advance
		end else if (advance) begin
			word <= next_word;
		end
	end

endmodule

/* pattern_config.sv */
/*
 * pattern configuration registers
 * decodes write strobes into enable, mode, fixed word and an LFSR reseed pulse
 */
`timescale 1ns/1ps

module pattern_config (
	input logic clock,
	input logic reset,
	input logic write,
	input serdes_pkg::addr_t address,
	input serdes_pkg::word_t write_data,
	pattern_config_if.source config_port
);

	logic write_control;
	logic write_fixed;
	logic write_reseed;

	// address decode
	assign write_control = write && (address == serdes_pkg::ADDR_CONTROL);
	assign write_fixed = write && (address == serdes_pkg::ADDR_FIXED);
	assign write_reseed = write && (address == serdes_pkg::ADDR_RESEED);

	// control register
	always_ff @(posedge clock) begin
		if (reset) begin
			config_port.enable <= 1'b0;
			config_port.mode <= serdes_pkg::MODE_FRAME;
		end else if (write_control) begin
			config_port.enable <= write_data[0];
			config_port.mode <= serdes_pkg::pattern_mode_t'(write_data[2:1]); // 3 kept as is
		end
	end

	// fixed word register
	always_ff @(posedge clock) begin
		if (reset) begin
			config_port.fixed_word <= '0;
		end else if (write_fixed) begin
			config_port.fixed_word <= write_data;
		end
	end

	/* the reseed pulse follows the strobe by one edge and lasts one cycle,
	   any data written with it is dropped */
	always_ff @(posedge clock) begin
		if (reset) begin
			config_port.reseed <= 1'b0;
		end else begin
			config_port.reseed <= write_reseed;
		end
	end

endmodule

/* pattern_config_if.sv */
/*
 * pattern configuration bundle
 * carries enable, mode, fixed word and reseed pulse to the sequencer
 */
`timescale 1ns/1ps

interface pattern_config_if;

	logic enable; // level
	serdes_pkg::pattern_mode_t mode; // level
	serdes_pkg::word_t fixed_word; // level
	logic reseed; // one-cycle pulse

	modport source (
		output enable,
		output mode,
		output fixed_word,
		output reseed
	);

	modport sink (
		input enable,
		input mode,
		input fixed_word,
		input reseed
	);

endinterface

/* serdes_pkg.sv */
/*
 * serdes link test package
 * widths, frame slot constants, LFSR seed and taps, register map and pattern modes
 */
package serdes_pkg;

	// parallel word into the serializer
	localparam int WORD_WIDTH = 10;
	typedef logic [WORD_WIDTH-1:0] word_t;

	// pattern frame layout
	localparam int FRAME_SLOTS = 32;
	typedef logic [4:0] slot_t;
	localparam slot_t RAMP_LAST = 5'd10; // slots 1..10 are the ramp
	localparam slot_t ALT_SLOT = 5'd11;
	localparam slot_t PRBS_SLOT = 5'd12;
	localparam word_t ALT_WORD = 10'b0101010101;

	// pseudo-random source, x^32+x^22+x^2+x+1
	localparam int PRBS_WIDTH = 32;
	typedef logic [PRBS_WIDTH-1:0] prbs_t;
	localparam prbs_t PRBS_SEED = 32'h0000_0001;
	localparam prbs_t PRBS_TAPS = 32'h8020_0003; // galois mask, right shift

	// serial frame: start, ten data bits, stop
	localparam int BITS_PER_FRAME = 12;
	typedef logic [3:0] bit_count_t;

	// configuration register map
	localparam int ADDR_WIDTH = 2;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	localparam addr_t ADDR_CONTROL = 2'd0; // bit 0 enable, bits 2:1 mode
	localparam addr_t ADDR_FIXED = 2'd1;
	localparam addr_t ADDR_RESEED = 2'd2; // write strobe only, data ignored

	/* code 3 is treated as MODE_FRAME by the sequencer */
	typedef enum logic [1:0] {
		MODE_FRAME = 2'd0,
		MODE_PRBS = 2'd1,
		MODE_FIXED = 2'd2
	} pattern_mode_t;

endpackage
